// ==== source/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Data word width
`define RV_XLEN 32

`endif

// ==== source/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_EXEC,
        EX_MEM_WAIT,
        EX_HALTED
    } exec_state_t;

    // Master side of the four-phase handshake
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQ,
        BUS_RELEASE
    } bus_state_t;

    typedef enum logic [1:0] {
        ARB_FREE,
        ARB_GRANT_FETCH,
        ARB_GRANT_DATA
    } arb_state_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module fetch_unit
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_instr_take,
    input  logic  i_redirect,
    input  word_t i_redirect_pc,
    output logic  o_instr_valid,
    output word_t o_instr,
    output word_t o_instr_pc,
    output logic  o_req,
    output word_t o_addr,
    input  logic  i_ack,
    input  word_t i_rdata
);

    bus_state_t state;
    word_t      fetch_pc;
    word_t      bus_addr;
    word_t      buf_instr;
    logic       buf_valid;
    logic       discard;
    logic       issue;
    logic       done;

    // Only fetch when the buffer is free by the time the word returns
    assign issue = (state == BUS_IDLE) && (!buf_valid || i_instr_take) && !i_redirect;
    assign done  = (state == BUS_RELEASE) && !i_ack;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= BUS_IDLE;
            fetch_pc  <= `RV_RESET_PC;
            buf_valid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (issue) begin
                        fetch_pc <= fetch_pc + 32'd4;
                        state    <= BUS_REQ;
                    end
                end
                BUS_REQ: if (i_ack) state <= BUS_RELEASE;
                BUS_RELEASE: if (!i_ack) state <= BUS_IDLE;
                default: state <= BUS_IDLE;
            endcase

            if (i_redirect) begin
                buf_valid <= 1'b0;
                fetch_pc  <= i_redirect_pc;
            end else if (done) begin
                buf_valid <= !discard;
            end else if (i_instr_take) begin
                buf_valid <= 1'b0;
            end

            // Word still on the bus belongs to the old path
            if (i_redirect && state != BUS_IDLE && !done)
                discard <= 1'b1;
            else if (done)
                discard <= 1'b0;
        end
    end

    // bus_addr stays put while the buffer is full, so it doubles as the buffered PC
    always_ff @(posedge clk) begin
        if (issue)
            bus_addr <= fetch_pc;
        if (state == BUS_REQ && i_ack)
            buf_instr <= i_rdata;
    end

    assign o_req         = (state == BUS_REQ);
    assign o_addr        = bus_addr;
    assign o_instr_valid = buf_valid;
    assign o_instr       = buf_instr;
    assign o_instr_pc    = bus_addr;

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_start,
    input  logic  i_we,
    input  word_t i_addr,
    input  word_t i_wdata,
    output logic  o_done,
    output word_t o_rdata,
    output logic  o_req,
    output logic  o_we,
    output word_t o_addr,
    output word_t o_wdata,
    input  logic  i_ack,
    input  word_t i_rdata
);

    bus_state_t state;
    logic       we_q;
    word_t      addr_q;
    word_t      wdata_q;
    word_t      rdata_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: if (i_start) state <= BUS_REQ;
                BUS_REQ: if (i_ack) state <= BUS_RELEASE;
                BUS_RELEASE: if (!i_ack) state <= BUS_IDLE;
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Request held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && i_start) begin
            we_q    <= i_we;
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
        end
        if (state == BUS_REQ && i_ack)
            rdata_q <= i_rdata;
    end

    assign o_req   = (state == BUS_REQ);
    assign o_we    = o_req && we_q;
    assign o_addr  = addr_q;
    assign o_wdata = wdata_q;

    // Pulse in the cycle ack is seen low again
    assign o_done  = (state == BUS_RELEASE) && !i_ack;
    assign o_rdata = rdata_q;

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_f_req,
    input  word_t i_f_addr,
    output logic  o_f_ack,
    output word_t o_f_rdata,
    input  logic  i_d_req,
    input  logic  i_d_we,
    input  word_t i_d_addr,
    input  word_t i_d_wdata,
    output logic  o_d_ack,
    output word_t o_d_rdata,
    output logic  o_mem_req,
    output logic  o_mem_we,
    output word_t o_mem_addr,
    output word_t o_mem_wdata,
    input  logic  i_mem_ack,
    input  word_t i_mem_rdata
);

    arb_state_t state;

    // Grant held through all four phases with the data port first
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ARB_FREE;
        end else begin
            case (state)
                ARB_FREE: begin
                    if (i_d_req)
                        state <= ARB_GRANT_DATA;
                    else if (i_f_req)
                        state <= ARB_GRANT_FETCH;
                end
                ARB_GRANT_FETCH: if (!i_f_req && !i_mem_ack) state <= ARB_FREE;
                ARB_GRANT_DATA: if (!i_d_req && !i_mem_ack) state <= ARB_FREE;
                default: state <= ARB_FREE;
            endcase
        end
    end

    always_comb begin
        o_mem_req   = 1'b0;
        o_mem_we    = 1'b0;
        o_mem_addr  = i_f_addr;
        o_mem_wdata = '0;
        case (state)
            ARB_GRANT_FETCH: begin
                o_mem_req = i_f_req;
            end
            ARB_GRANT_DATA: begin
                o_mem_req   = i_d_req;
                o_mem_we    = i_d_we;
                o_mem_addr  = i_d_addr;
                o_mem_wdata = i_d_wdata;
            end
            default: ;
        endcase
    end

    assign o_f_ack   = (state == ARB_GRANT_FETCH) && i_mem_ack;
    assign o_d_ack   = (state == ARB_GRANT_DATA) && i_mem_ack;
    assign o_f_rdata = i_mem_rdata;
    assign o_d_rdata = i_mem_rdata;

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import rv_pkg::*;
(
    input  word_t     i_instr,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output reg_addr_t o_rd,
    output word_t     o_imm,
    output alu_op_t   o_alu_op,
    output logic      o_use_imm,
    output logic      o_reg_write,
    output logic      o_is_load,
    output logic      o_is_store,
    output logic      o_is_beq,
    output logic      o_is_bne,
    output logic      o_is_jal,
    output logic      o_is_halt
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam word_t      ECALL      = 32'h0000_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign o_rd   = i_instr[11:7];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // Anything not listed falls through as a no-op
    always_comb begin
        o_imm       = imm_i;
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_beq    = 1'b0;
        o_is_bne    = 1'b0;
        o_is_jal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                o_reg_write = 1'b1;
                case (funct3)
                    3'b000: o_alu_op = i_instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010: o_alu_op = ALU_SLT;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    default: o_reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
                case (funct3)
                    3'b000: o_alu_op = ALU_ADD;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    default: o_reg_write = 1'b0;
                endcase
            end
            OPC_LUI: begin
                o_imm       = imm_u;
                o_alu_op    = ALU_PASS_B;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            OPC_LOAD: begin
                // Word loads only
                o_use_imm   = 1'b1;
                o_reg_write = (funct3 == 3'b010);
                o_is_load   = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                o_imm      = imm_s;
                o_use_imm  = 1'b1;
                o_is_store = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                o_imm    = imm_b;
                o_is_beq = (funct3 == 3'b000);
                o_is_bne = (funct3 == 3'b001);
            end
            OPC_JAL: begin
                o_imm       = imm_j;
                o_reg_write = 1'b1;
                o_is_jal    = 1'b1;
            end
            default: ;
        endcase
    end

    assign o_is_halt = (i_instr == ECALL);

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    output word_t     o_rdata1,
    output word_t     o_rdata2,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata
);

    word_t regs [32];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (i_we && i_waddr != 5'd0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_rs1];
    assign o_rdata2 = regs[i_rs2];

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_instr_valid,
    input  word_t     i_instr,
    input  word_t     i_instr_pc,
    output logic      o_instr_take,
    output logic      o_redirect,
    output word_t     o_redirect_pc,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    input  word_t     i_rdata1,
    input  word_t     i_rdata2,
    output logic      o_rf_we,
    output reg_addr_t o_rf_waddr,
    output word_t     o_rf_wdata,
    output logic      o_ls_start,
    output logic      o_ls_we,
    output word_t     o_ls_addr,
    output word_t     o_ls_wdata,
    input  logic      i_ls_done,
    input  word_t     i_ls_rdata,
    output logic      o_halt
);

    exec_state_t state;
    word_t       instr_q;
    word_t       pc_q;
    word_t       imm;
    word_t       alu_b;
    word_t       alu_result;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_bne;
    logic        is_jal;
    logic        is_halt;
    logic        in_exec;
    logic        taken;

    instr_decoder decoder_inst (
        .i_instr(instr_q),
        .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rf_waddr),
        .o_imm(imm), .o_alu_op(alu_op), .o_use_imm(use_imm),
        .o_reg_write(reg_write), .o_is_load(is_load), .o_is_store(is_store),
        .o_is_beq(is_beq), .o_is_bne(is_bne), .o_is_jal(is_jal),
        .o_is_halt(is_halt)
    );

    assign alu_b = use_imm ? imm : i_rdata2;

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_result = i_rdata1 - alu_b;
            ALU_AND:    alu_result = i_rdata1 & alu_b;
            ALU_OR:     alu_result = i_rdata1 | alu_b;
            ALU_XOR:    alu_result = i_rdata1 ^ alu_b;
            ALU_SLT:    alu_result = word_t'($signed(i_rdata1) < $signed(alu_b));
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = i_rdata1 + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE: if (o_instr_take) state <= EX_EXEC;
                EX_EXEC: begin
                    if (is_halt)
                        state <= EX_HALTED;
                    else if (is_load || is_store)
                        state <= EX_MEM_WAIT;
                    else
                        state <= EX_IDLE;
                end
                EX_MEM_WAIT: if (i_ls_done) state <= EX_IDLE;
                default: state <= EX_HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_instr_take) begin
            instr_q <= i_instr;
            pc_q    <= i_instr_pc;
        end
    end

    assign in_exec      = (state == EX_EXEC);
    assign o_instr_take = (state == EX_IDLE) && i_instr_valid;
    assign taken        = (is_beq && i_rdata1 == i_rdata2) || (is_bne && i_rdata1 != i_rdata2);

    // Branch and jump target share the PC-relative adder
    assign o_redirect    = in_exec && (is_jal || taken);
    assign o_redirect_pc = pc_q + imm;

    assign o_ls_start = in_exec && (is_load || is_store);
    assign o_ls_we    = is_store;
    assign o_ls_addr  = alu_result;
    assign o_ls_wdata = i_rdata2;

    // Loads write back when the bus transaction ends
    assign o_rf_we    = (in_exec && reg_write && !is_load) ||
                        (state == EX_MEM_WAIT && i_ls_done && is_load);
    assign o_rf_wdata = (state == EX_MEM_WAIT) ? i_ls_rdata :
                        is_jal ? pc_q + 32'd4 : alu_result;

    assign o_halt = (state == EX_HALTED);

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst,
    output logic  o_mem_req,
    output logic  o_mem_we,
    output word_t o_mem_addr,
    output word_t o_mem_wdata,
    input  word_t i_mem_rdata,
    input  logic  i_mem_ack,
    output logic  o_halt
);

    // Fetch side of the arbiter
    logic  f_req;
    logic  f_ack;
    word_t f_addr;
    word_t f_rdata;

    // Data side of the arbiter
    logic  d_req;
    logic  d_we;
    logic  d_ack;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata;

    // Fetch to execute
    logic  instr_valid;
    logic  instr_take;
    logic  redirect;
    word_t instr;
    word_t instr_pc;
    word_t redirect_pc;

    // Register file
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rf_waddr;
    logic      rf_we;
    word_t     rdata1;
    word_t     rdata2;
    word_t     rf_wdata;

    // Execute to load/store
    logic  ls_start;
    logic  ls_we;
    logic  ls_done;
    word_t ls_addr;
    word_t ls_wdata;
    word_t ls_rdata;

    fetch_unit fetch_unit_inst (
        .clk(clk), .i_rst(i_rst),
        .i_instr_take(instr_take),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .o_instr_valid(instr_valid), .o_instr(instr), .o_instr_pc(instr_pc),
        .o_req(f_req), .o_addr(f_addr), .i_ack(f_ack), .i_rdata(f_rdata)
    );

    load_store_unit load_store_unit_inst (
        .clk(clk), .i_rst(i_rst),
        .i_start(ls_start), .i_we(ls_we), .i_addr(ls_addr), .i_wdata(ls_wdata),
        .o_done(ls_done), .o_rdata(ls_rdata),
        .o_req(d_req), .o_we(d_we), .o_addr(d_addr), .o_wdata(d_wdata),
        .i_ack(d_ack), .i_rdata(d_rdata)
    );

    bus_arbiter bus_arbiter_inst (
        .clk(clk), .i_rst(i_rst),
        .i_f_req(f_req), .i_f_addr(f_addr), .o_f_ack(f_ack), .o_f_rdata(f_rdata),
        .i_d_req(d_req), .i_d_we(d_we), .i_d_addr(d_addr), .i_d_wdata(d_wdata),
        .o_d_ack(d_ack), .o_d_rdata(d_rdata),
        .o_mem_req(o_mem_req), .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .i_mem_ack(i_mem_ack), .i_mem_rdata(i_mem_rdata)
    );

    reg_file reg_file_inst (
        .clk(clk), .i_rst(i_rst),
        .i_rs1(rs1), .i_rs2(rs2), .o_rdata1(rdata1), .o_rdata2(rdata2),
        .i_we(rf_we), .i_waddr(rf_waddr), .i_wdata(rf_wdata)
    );

    execute_unit execute_unit_inst (
        .clk(clk), .i_rst(i_rst),
        .i_instr_valid(instr_valid), .i_instr(instr), .i_instr_pc(instr_pc),
        .o_instr_take(instr_take),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_rs1(rs1), .o_rs2(rs2), .i_rdata1(rdata1), .i_rdata2(rdata2),
        .o_rf_we(rf_we), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
        .o_ls_start(ls_start), .o_ls_we(ls_we),
        .o_ls_addr(ls_addr), .o_ls_wdata(ls_wdata),
        .i_ls_done(ls_done), .i_ls_rdata(ls_rdata),
        .o_halt(o_halt)
    );

endmodule

// ==== verification/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
    input logic clk,
    input logic i_rst,
    input logic i_mem_req,
    input logic i_mem_we,
    input logic i_mem_ack,
    input logic i_halt
);

    // Four-phase master rules on the shared bus
    req_until_ack: assert property (@(posedge clk) disable iff (i_rst)
        i_mem_req && !i_mem_ack |=> i_mem_req)
        else $error("memory request dropped before acknowledge");

    req_after_ack_low: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_mem_req) |-> !i_mem_ack)
        else $error("memory request raised while acknowledge still high");

    we_with_req: assert property (@(posedge clk) disable iff (i_rst)
        i_mem_we |-> i_mem_req)
        else $error("write enable without a request");

    halt_sticky: assert property (@(posedge clk) disable iff (i_rst)
        i_halt |=> i_halt)
        else $error("halt dropped without reset");

    // A fetch issued with the ECALL take may still be granted in the halt cycle
    no_req_after_halt: assert property (@(posedge clk) disable iff (i_rst)
        $rose(i_mem_req) |-> !$past(i_halt))
        else $error("new memory request after halt");

endmodule

bind rv_core_top rv_core_assert core_assert_inst (
    .clk(clk), .i_rst(i_rst),
    .i_mem_req(o_mem_req), .i_mem_we(o_mem_we),
    .i_mem_ack(i_mem_ack), .i_halt(o_halt)
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          NUM_TESTS      = 29;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED           = 32'h1199ddac;

    // RV32I opcodes and the halt word
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_STORE  = 7'b0100011;
    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;
    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] X1 = 5'd1;
    localparam logic [4:0] X2 = 5'd2;
    localparam logic [4:0] X3 = 5'd3;

    localparam logic [11:0] RESULT_OFF = 12'h100;
    localparam logic [7:0]  RESULT_IDX = 8'h40;
    localparam logic [11:0] MARKER     = 12'h055;
    // JAL follows the two constant loads
    localparam logic [31:0] JAL_ADDR   = 32'd16;

    localparam logic MODE_FIXED  = 1'b0;
    localparam logic MODE_RANDOM = 1'b1;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_ANDI,
        OP_ORI, OP_XORI, OP_LUI, OP_LOAD, OP_BEQ, OP_BNE, OP_JAL, OP_X0
    } test_op_t;

    typedef struct packed {
        test_op_t    op;
        logic [31:0] a;
        logic [31:0] b;
        logic        mode;
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{OP_ADD,  32'h0000_0007, 32'h0000_0005, MODE_FIXED},
        '{OP_ADD,  32'hffff_ffff, 32'h0000_0001, MODE_FIXED},
        '{OP_ADD,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_SUB,  32'h0000_0005, 32'h0000_0007, MODE_FIXED},
        '{OP_SUB,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_AND,  32'hf0f0_1234, 32'hff00_ff00, MODE_FIXED},
        '{OP_AND,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_OR,   32'h0f0f_0000, 32'h0000_f0f0, MODE_FIXED},
        '{OP_OR,   32'h0,         32'h0,         MODE_RANDOM},
        '{OP_XOR,  32'ha5a5_a5a5, 32'hffff_0000, MODE_FIXED},
        '{OP_XOR,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_SLT,  32'hffff_fff0, 32'h0000_0003, MODE_FIXED},
        '{OP_SLT,  32'h0000_0003, 32'hffff_fff0, MODE_FIXED},
        '{OP_SLT,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_ADDI, 32'h0000_0064, 32'h0000_0fff, MODE_FIXED},
        '{OP_ANDI, 32'h1234_5678, 32'h0000_00f0, MODE_FIXED},
        '{OP_ORI,  32'h1234_5000, 32'h0000_08ab, MODE_FIXED},
        '{OP_XORI, 32'hdead_beef, 32'h0000_07ff, MODE_FIXED},
        '{OP_ADDI, 32'h0,         32'h0,         MODE_RANDOM},
        '{OP_LUI,  32'h0000_0000, 32'habcd_e123, MODE_FIXED},
        '{OP_LUI,  32'h0,         32'h0,         MODE_RANDOM},
        '{OP_LOAD, 32'h1234_5678, 32'h0000_0000, MODE_FIXED},
        '{OP_LOAD, 32'hffff_ffff, 32'h0000_0000, MODE_FIXED},
        '{OP_BEQ,  32'h0000_0005, 32'h0000_0005, MODE_FIXED},
        '{OP_BEQ,  32'h0000_0005, 32'h0000_0006, MODE_FIXED},
        '{OP_BNE,  32'h0000_0005, 32'h0000_0005, MODE_FIXED},
        '{OP_BNE,  32'h0000_0005, 32'h0000_0006, MODE_FIXED},
        '{OP_JAL,  32'h0000_0000, 32'h0000_0000, MODE_FIXED},
        '{OP_X0,   32'h0000_0123, 32'h0000_0000, MODE_FIXED}
    };

    logic        clk       = 1'b0;
    logic        rst       = 1'b1;
    logic        mem_ack   = 1'b0;
    logic [31:0] mem_rdata = 32'h0;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        halt;

    logic [31:0] mem   [256];
    logic [31:0] image [256];
    logic        busy  = 1'b0;
    logic [1:0]  delay = 2'd0;
    logic [7:0]  prog_len;
    logic [4:0]  test_idx;
    int          pass_count = 0;
    int          fail_count = 0;

    always #4 clk = ~clk;

    rv_core_top dut0 (
        .clk(clk), .i_rst(rst),
        .o_mem_req(mem_req), .o_mem_we(mem_we),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
        .i_mem_rdata(mem_rdata), .i_mem_ack(mem_ack),
        .o_halt(halt)
    );

    // Memory model reloads its image while reset is held
    always @(negedge clk) begin
        if (rst) begin
            mem     <= image;
            mem_ack <= 1'b0;
            busy    <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!busy) begin
                busy  <= 1'b1;
                delay <= 2'($urandom_range(3, 0));
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_addr[9:2]];
                if (mem_we)
                    mem[mem_addr[9:2]] <= mem_wdata;
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack <= 1'b0;
            busy    <= 1'b0;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // ISA result of each test program
    function automatic logic [31:0] expected_value(input test_op_t op, input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [31:0] imm;
        imm = {{20{b[11]}}, b[11:0]};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + imm;
            OP_ANDI: return a & imm;
            OP_ORI:  return a | imm;
            OP_XORI: return a ^ imm;
            OP_LUI:  return {b[31:12], 12'h000};
            OP_LOAD: return a + 32'd1;
            OP_BEQ:  return (a == b) ? 32'd0 : {20'h0, MARKER};
            OP_BNE:  return (a != b) ? 32'd0 : {20'h0, MARKER};
            OP_JAL:  return JAL_ADDR + 32'd4;
            default: return 32'd0;
        endcase
    endfunction

    task automatic put(input logic [31:0] instr);
        image[prog_len] = instr;
        prog_len = prog_len + 8'd1;
    endtask

    // LUI plus ADDI with the upper part rounded for the sign of the low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'h0, value[11]};
        put({upper, rd, OPC_LUI});
        put(i_type(value[11:0], rd, 3'b000, rd, OPC_IMM));
    endtask

    task automatic build_program(input test_op_t op, input logic [31:0] a,
                                 input logic [31:0] b);
        logic [4:0] res_reg;
        for (int i = 0; i < 256; i++)
            image[i[7:0]] = 32'hbad0_0000 + i;
        prog_len = 8'd0;
        res_reg  = X3;
        load_const(X1, a);
        load_const(X2, b);
        case (op)
            OP_ADD:  put(r_type(7'h00, X2, X1, 3'b000, X3));
            OP_SUB:  put(r_type(7'h20, X2, X1, 3'b000, X3));
            OP_AND:  put(r_type(7'h00, X2, X1, 3'b111, X3));
            OP_OR:   put(r_type(7'h00, X2, X1, 3'b110, X3));
            OP_XOR:  put(r_type(7'h00, X2, X1, 3'b100, X3));
            OP_SLT:  put(r_type(7'h00, X2, X1, 3'b010, X3));
            OP_ADDI: put(i_type(b[11:0], X1, 3'b000, X3, OPC_IMM));
            OP_ANDI: put(i_type(b[11:0], X1, 3'b111, X3, OPC_IMM));
            OP_ORI:  put(i_type(b[11:0], X1, 3'b110, X3, OPC_IMM));
            OP_XORI: put(i_type(b[11:0], X1, 3'b100, X3, OPC_IMM));
            OP_LUI:  put({b[31:12], X3, OPC_LUI});
            OP_LOAD: begin
                image[RESULT_IDX] = a;
                put(i_type(RESULT_OFF, X0, 3'b010, X3, OPC_LOAD));
                put(i_type(12'h001, X3, 3'b000, X3, OPC_IMM));
            end
            OP_BEQ, OP_BNE: begin
                put(branch_word(13'd8, X2, X1, (op == OP_BEQ) ? 3'b000 : 3'b001));
                put(i_type(MARKER, X0, 3'b000, X3, OPC_IMM));
            end
            OP_JAL: begin
                put(jal_word(21'd8, X3));
                put(i_type(MARKER, X0, 3'b000, X3, OPC_IMM));
            end
            default: begin
                put(i_type(a[11:0], X1, 3'b000, X0, OPC_IMM));
                res_reg = X0;
            end
        endcase
        put(store_word(RESULT_OFF, res_reg, X0));
        put(ECALL_WORD);
    endtask

    task automatic run_test(input logic [4:0] t);
        test_row_t   row;
        test_op_t    op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [31:0] got;
        logic        prev_req;
        logic        halt_dropped;
        int          req_rises;
        int          cycles;

        row = tests[t];
        op  = row.op;
        a   = row.a;
        b   = row.b;
        if (row.mode == MODE_RANDOM) begin
            a = $urandom;
            b = $urandom;
        end

        @(negedge clk);
        build_program(op, a, b);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        cycles = 0;
        while (!halt && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end

        if (!halt) begin
            $display("test %0d %s: core did not halt within %0d cycles",
                     t, op.name(), TIMEOUT_CYCLES);
            fail_count++;
        end else begin
            // Bus must stay quiet and halt must hold
            prev_req     = mem_req;
            halt_dropped = 1'b0;
            req_rises    = 0;
            repeat (12) begin
                @(negedge clk);
                if (mem_req && !prev_req)
                    req_rises++;
                if (!halt)
                    halt_dropped = 1'b1;
                prev_req = mem_req;
            end
            expected = expected_value(op, a, b);
            got      = mem[RESULT_IDX];
            if (got !== expected) begin
                $display("FAIL at %0t: test %0d %s a=%h b=%h expected %h got %h",
                         $time, t, op.name(), a, b, expected, got);
                fail_count++;
            end else if (halt_dropped || req_rises != 0) begin
                $display("test %0d %s: halt did not hold or the bus was used after halt",
                         t, op.name());
                fail_count++;
            end else begin
                $display("test %0d %s: pass, stored %h", t, op.name(), got);
                pass_count++;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        for (test_idx = 5'd0; test_idx < 5'(NUM_TESTS); test_idx++)
            run_test(test_idx);
        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/rv_pkg.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/instr_decoder.sv
source/reg_file.sv
source/execute_unit.sv
source/rv_core_top.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
